//--- Makefile
TOP = tb_regbank

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- axil_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axil_if (
    input logic axi_if,
    input logic rst_n
);

    // write address / data / response
    regbank_pkg::addr_t awaddr;
    logic               awvalid;
    logic               awready;
    regbank_pkg::data_t wdata;
    regbank_pkg::strb_t wstrb;
    logic               wvalid;
    logic               wready;
    regbank_pkg::resp_t bresp;
    logic               bvalid;
    logic               bready;

    // read address / data
    regbank_pkg::addr_t araddr;
    logic               arvalid;
    logic               arready;
    regbank_pkg::data_t rdata;
    regbank_pkg::resp_t rresp;
    logic               rvalid;
    logic               rready;

    modport wr (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bvalid, bresp
    );

    modport rd (
        input  araddr, arvalid, rready,
        output arready, rvalid, rdata, rresp
    );

    // passive view, used by protocol checks
    modport mon (
        input axi_if, rst_n,
        input awaddr, awvalid, awready, wdata, wstrb, wvalid, wready,
        input bresp, bvalid, bready,
        input araddr, arvalid, arready, rdata, rresp, rvalid, rready
    );

endinterface

`default_nettype wire

//--- axil_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbank_settings.svh"

module axil_read_ctrl (
    input logic          axi_if,
    input logic          rst_n,
    axil_if.rd           bus,
    reg_access_if.reader acc
);

    import regbank_pkg::*;

    rd_state_t state;
    addr_t     addr_q;
    logic      ar_hs;
    logic      load;

    assign ar_hs = (state == R_IDLE) && bus.arvalid && bus.arready;
    assign load  = (state == R_DATA) && !bus.rvalid;  // first cycle after AR

    assign acc.rd_addr = addr_q;

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            state       <= R_IDLE;
            bus.arready <= 1'b0;
            bus.rvalid  <= 1'b0;
        end else begin
            bus.arready <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (ar_hs) begin
                        state <= R_DATA;
                    end else if (bus.arvalid) begin
                        bus.arready <= 1'b1;
                    end
                end
                R_DATA: begin
                    if (load) begin
                        bus.rvalid <= 1'b1;
                    end else if (bus.rready) begin
                        bus.rvalid <= 1'b0;
                        state      <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // address and read payload, held while rvalid is up
    always_ff @(posedge axi_if) begin
        if (ar_hs) begin
            addr_q <= bus.araddr;
        end
        if (load) begin
            bus.rdata <= acc.rd_err ? `ERR_DATA : acc.rd_data;
            bus.rresp <= acc.rd_err ? `RESP_SLVERR : `RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

//--- axil_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbank_settings.svh"

module axil_write_ctrl (
    input logic          axi_if,
    input logic          rst_n,
    axil_if.wr           bus,
    reg_access_if.writer acc
);

    import regbank_pkg::*;

    wr_state_t state;
    addr_t     addr_q;
    data_t     data_q;
    strb_t     strb_q;
    logic      aw_hs;
    logic      w_hs;

    assign aw_hs = (state == W_IDLE) && bus.awvalid && bus.awready;
    assign w_hs  = (state == W_DATA) && bus.wvalid && bus.wready;

    // commit request towards the register file
    assign acc.wr_en   = (state == W_COMMIT);
    assign acc.wr_addr = addr_q;
    assign acc.wr_data = data_q;
    assign acc.wr_strb = strb_q;

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            state       <= W_IDLE;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.bvalid  <= 1'b0;
        end else begin
            bus.awready <= 1'b0;  // ready is a single-cycle pulse
            bus.wready  <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (aw_hs) begin
                        state <= W_DATA;
                    end else if (bus.awvalid) begin
                        bus.awready <= 1'b1;
                    end
                end
                W_DATA: begin
                    if (w_hs) begin
                        state <= W_COMMIT;
                    end else if (bus.wvalid) begin
                        bus.wready <= 1'b1;
                    end
                end
                W_COMMIT: begin
                    bus.bvalid <= 1'b1;
                    state      <= W_RESP;
                end
                W_RESP: begin
                    // hold response until the master takes it
                    if (bus.bready) begin
                        bus.bvalid <= 1'b0;
                        state      <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // captured transaction and response code
    always_ff @(posedge axi_if) begin
        if (aw_hs) begin
            addr_q <= bus.awaddr;
        end
        if (w_hs) begin
            data_q <= bus.wdata;
            strb_q <= bus.wstrb;
        end
        if (state == W_COMMIT) begin
            bus.bresp <= acc.wr_err ? `RESP_SLVERR : `RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
regbank_pkg.sv
axil_if.sv
reg_access_if.sv
reg_file.sv
axil_write_ctrl.sv
axil_read_ctrl.sv
regbank_top.sv
regbank_asserts.sv
tb_regbank.sv

//--- reg_access_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;

    // write side
    logic               wr_en;      // one-cycle commit strobe
    regbank_pkg::addr_t wr_addr;
    regbank_pkg::data_t wr_data;
    regbank_pkg::strb_t wr_strb;
    logic               wr_err;     // bad address or read-only target

    // read side
    regbank_pkg::addr_t rd_addr;
    regbank_pkg::data_t rd_data;
    logic               rd_err;

    modport writer (
        output wr_en, wr_addr, wr_data, wr_strb,
        input  wr_err
    );

    modport reader (
        output rd_addr,
        input  rd_data, rd_err
    );

    modport regs (
        input  wr_en, wr_addr, wr_data, wr_strb, rd_addr,
        output wr_err, rd_data, rd_err
    );

endinterface

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbank_settings.svh"

module reg_file (
    input logic        axi_if,
    input logic        rst_n,
    reg_access_if.regs acc
);

    import regbank_pkg::*;

    localparam logic [`REG_COUNT-1:0] ro_mask = `RO_MASK;

    data_t    regs [`REG_COUNT];
    reg_idx_t wr_idx;
    reg_idx_t rd_idx;
    logic     wr_ok;
    logic     rd_ok;

    // word aligned and inside the 16-word window
    function automatic logic addr_ok(addr_t addr);
        addr_t offset;
        offset = addr - `BASE_ADDR;
        return (addr[1:0] == 2'b00) &&
               (addr >= `BASE_ADDR) &&
               (offset < addr_t'(`REG_COUNT * 4));
    endfunction

    function automatic reg_idx_t addr_idx(addr_t addr);
        addr_t offset;
        offset = addr - `BASE_ADDR;
        return offset[5:2];
    endfunction

    // write decode
    assign wr_idx     = addr_idx(acc.wr_addr);
    assign wr_ok      = addr_ok(acc.wr_addr);
    assign acc.wr_err = !wr_ok || ro_mask[wr_idx];

    // read decode, data is a plain mux
    assign rd_idx      = addr_idx(acc.rd_addr);
    assign rd_ok       = addr_ok(acc.rd_addr);
    assign acc.rd_err  = !rd_ok;
    assign acc.rd_data = regs[rd_idx];

    always_ff @(posedge axi_if) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[0] <= `RST_CONTROL;
            regs[1] <= `RST_STATUS;
            regs[2] <= `RST_CONFIG;
            regs[3] <= `RST_VERSION;
        end else if (acc.wr_en && !acc.wr_err) begin
            // merge strobed byte lanes only
            for (int b = 0; b < 4; b++) begin
                if (acc.wr_strb[b]) begin
                    regs[wr_idx][8*b +: 8] <= acc.wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- regbank_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module regbank_asserts (
    input logic               axi_if,
    input logic               rst_n,
    input logic               awready,
    input logic               wready,
    input regbank_pkg::resp_t bresp,
    input logic               bvalid,
    input logic               bready,
    input logic               arvalid,
    input logic               arready,
    input regbank_pkg::data_t rdata,
    input regbank_pkg::resp_t rresp,
    input logic               rvalid,
    input logic               rready
);

    int assert_fails = 0;  // failures seen so far

    // responses held until the master takes them
    b_hold: assert property (@(posedge axi_if) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("bvalid dropped or bresp changed before bready");
            assert_fails++;
        end

    r_hold: assert property (@(posedge axi_if) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("rvalid dropped or read payload changed before rready");
            assert_fails++;
        end

    // no new write address while a response is pending
    aw_quiet: assert property (@(posedge axi_if) disable iff (!rst_n)
        !(awready && bvalid))
        else begin
            $error("awready high while bvalid is pending");
            assert_fails++;
        end

    reset_idle: assert property (@(posedge axi_if)
        $rose(rst_n) |-> !awready && !wready && !bvalid && !arready && !rvalid)
        else begin
            $error("handshake output high in the first cycle after reset");
            assert_fails++;
        end

    // read data follows the AR handshake by two cycles
    r_latency: assert property (@(posedge axi_if) disable iff (!rst_n)
        arvalid && arready |-> ##2 rvalid)
        else begin
            $error("rvalid not high two cycles after the AR handshake");
            assert_fails++;
        end

endmodule

`default_nettype wire

//--- regbank_pkg.sv
`default_nettype none

package regbank_pkg;

    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] data_t;     // register word
    typedef logic [3:0]  strb_t;     // one bit per byte lane
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  reg_idx_t;  // word index into the bank

    // write channel, one transaction at a time
    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_COMMIT,
        W_RESP
    } wr_state_t;

    typedef enum logic {
        R_IDLE,
        R_DATA
    } rd_state_t;

endpackage

`default_nettype wire

//--- regbank_settings.svh
`ifndef REGBANK_SETTINGS_SVH
`define REGBANK_SETTINGS_SVH

// register map
`define REG_COUNT    16
`define BASE_ADDR    32'h0000_1000

// AXI response codes
`define RESP_OKAY    2'b00
`define RESP_SLVERR  2'b10

`define ERR_DATA     32'hDEAD_BEEF   // returned on a refused read

// reset values of registers 0 to 3, all others clear to zero
`define RST_CONTROL  32'h0000_0001
`define RST_STATUS   32'hABCD_1234
`define RST_CONFIG   32'h0000_00F0
`define RST_VERSION  32'h0001_0000

`define RO_MASK      16'h000A        // status and version are read-only

`endif

//--- regbank_top.sv
`timescale 1ns/1ps
`default_nettype none

module regbank_top (
    input  logic               axi_if,
    input  logic               rst_n,
    // write address
    input  regbank_pkg::addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    // write data
    input  regbank_pkg::data_t wdata,
    input  regbank_pkg::strb_t wstrb,
    input  logic               wvalid,
    output logic               wready,
    // write response
    output regbank_pkg::resp_t bresp,
    output logic               bvalid,
    input  logic               bready,
    // read address
    input  regbank_pkg::addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    // read data
    output regbank_pkg::data_t rdata,
    output regbank_pkg::resp_t rresp,
    output logic               rvalid,
    input  logic               rready
);

    import regbank_pkg::*;

    axil_if bus (
        .axi_if (axi_if),
        .rst_n  (rst_n)
    );

    reg_access_if acc ();

    // master side into the bus
    assign bus.awaddr  = awaddr;
    assign bus.awvalid = awvalid;
    assign bus.wdata   = wdata;
    assign bus.wstrb   = wstrb;
    assign bus.wvalid  = wvalid;
    assign bus.bready  = bready;
    assign bus.araddr  = araddr;
    assign bus.arvalid = arvalid;
    assign bus.rready  = rready;

    // slave side back out
    assign awready = bus.awready;
    assign wready  = bus.wready;
    assign bresp   = bus.bresp;
    assign bvalid  = bus.bvalid;
    assign arready = bus.arready;
    assign rdata   = bus.rdata;
    assign rresp   = bus.rresp;
    assign rvalid  = bus.rvalid;

    axil_write_ctrl u_write_ctrl (
        .axi_if (axi_if),
        .rst_n  (rst_n),
        .bus    (bus.wr),
        .acc    (acc.writer)
    );

    axil_read_ctrl u_read_ctrl (
        .axi_if (axi_if),
        .rst_n  (rst_n),
        .bus    (bus.rd),
        .acc    (acc.reader)
    );

    reg_file u_reg_file (
        .axi_if (axi_if),
        .rst_n  (rst_n),
        .acc    (acc.regs)
    );

endmodule

`default_nettype wire

//--- tb_regbank.sv
`timescale 1ns/1ps
`default_nettype none

`include "regbank_settings.svh"

module tb_regbank;

    import regbank_pkg::*;

    localparam logic [15:0] RO_BITS = `RO_MASK;
    localparam int TIMEOUT_CYCLES = 4000;  // ~150 transactions at up to 25 cycles, plus margin

    logic  axi_if, rst_n;
    addr_t awaddr, araddr;
    data_t wdata, rdata;
    strb_t wstrb;
    resp_t bresp, rresp;
    logic  awvalid, awready, wvalid, wready, bvalid, bready;
    logic  arvalid, arready, rvalid, rready;

    data_t  model [`REG_COUNT];  // expected register contents
    integer seed;
    logic   random_delays;
    int     cycle_count;
    int     check_count = 0;
    int     err_count = 0;
    int     test_errs, test_checks;
    string  test_name;
    string  name_q[$];           // compares waiting for the checker
    data_t  exp_q[$];
    data_t  act_q[$];
    string  cmp_name;
    data_t  cmp_exp, cmp_act;
    addr_t  addr;
    data_t  data;
    strb_t  strb;
    int     idx, other, op;
    addr_t  bad_list [6];

    regbank_top uut (.*);

    bind regbank_top regbank_asserts u_asserts (
        .axi_if(axi_if), .rst_n(rst_n), .awready(awready), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        axi_if = 1'b0;
        forever #2 axi_if = ~axi_if;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge axi_if);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // checker, drains whatever the bus tasks have queued
    always @(posedge axi_if) begin
        while (name_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            check_count++;
            assert (cmp_act == cmp_exp) else begin
                $display("Error: %s expected %h actual %h", cmp_name, cmp_exp, cmp_act);
                err_count++;
            end
        end
    end

    // register map rules: alignment, window, read-only bits, byte lanes
    function automatic data_t expect_value(input addr_t a, input data_t d, input strb_t s,
                                           input logic is_write, output resp_t resp);
        addr_t    offset;
        reg_idx_t i;
        data_t    val;
        offset = a - `BASE_ADDR;
        i      = offset[5:2];
        resp   = `RESP_SLVERR;
        if (a[1:0] != 2'b00 || a < `BASE_ADDR || offset >= addr_t'(`REG_COUNT * 4)) begin
            return `ERR_DATA;
        end
        val = model[i];
        if (is_write) begin
            if (RO_BITS[i]) return val;  // refused, value unchanged
            for (int b = 0; b < 4; b++) begin
                if (s[b]) val[8*b +: 8] = d[8*b +: 8];
            end
        end
        resp = `RESP_OKAY;
        return val;
    endfunction

    function automatic int pick_delay();
        if (!random_delays) return 0;
        return int'($unsigned($random(seed)) % 4);
    endfunction

    // mostly valid words, a few misaligned or past the window
    function automatic addr_t random_addr();
        int pick;
        pick = int'($unsigned($random(seed)) % 20);
        if (pick < 16) return `BASE_ADDR + addr_t'(4 * pick);
        if (pick < 18) return `BASE_ADDR + addr_t'(4 * (pick - 10) + pick - 15);
        return `BASE_ADDR + addr_t'(64 + 4 * pick);
    endfunction

    task automatic axi_write(input addr_t a, input data_t d, input strb_t s, output resp_t resp);
        repeat (pick_delay()) @(posedge axi_if);
        awaddr  <= a;
        awvalid <= 1'b1;
        do @(posedge axi_if); while (!awready);
        awvalid <= 1'b0;
        repeat (pick_delay()) @(posedge axi_if);
        wdata  <= d;
        wstrb  <= s;
        wvalid <= 1'b1;
        do @(posedge axi_if); while (!wready);
        wvalid <= 1'b0;
        repeat (pick_delay()) @(posedge axi_if);  // back-pressure on B
        bready <= 1'b1;
        do @(posedge axi_if); while (!(bvalid && bready));
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input addr_t a, output data_t d, output resp_t resp);
        repeat (pick_delay()) @(posedge axi_if);
        araddr  <= a;
        arvalid <= 1'b1;
        do @(posedge axi_if); while (!arready);
        arvalid <= 1'b0;
        repeat (pick_delay()) @(posedge axi_if);
        rready <= 1'b1;
        do @(posedge axi_if); while (!(rvalid && rready));
        d    = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic push_check(input string name, input data_t exp, input data_t act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic write_and_check(input string name, input addr_t a, input data_t d,
                                   input strb_t s);
        resp_t exp_resp;
        resp_t act_resp;
        data_t new_val;
        addr_t offset;
        new_val = expect_value(a, d, s, 1'b1, exp_resp);
        axi_write(a, d, s, act_resp);
        push_check({name, " bresp"}, data_t'(exp_resp), data_t'(act_resp));
        offset = a - `BASE_ADDR;
        if (exp_resp == `RESP_OKAY) model[offset[5:2]] = new_val;
    endtask

    task automatic read_and_check(input string name, input addr_t a);
        resp_t exp_resp;
        resp_t act_resp;
        data_t exp_data;
        data_t act_data;
        exp_data = expect_value(a, '0, '0, 1'b0, exp_resp);
        axi_read(a, act_data, act_resp);
        push_check({name, " rdata"}, exp_data, act_data);
        push_check({name, " rresp"}, data_t'(exp_resp), data_t'(act_resp));
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errs   = err_count;
        test_checks = check_count;
    endtask

    task automatic end_test();
        while (name_q.size() != 0) @(posedge axi_if);
        $display("test %-12s %0d checks, %0d errors", test_name,
                 check_count - test_checks, err_count - test_errs);
    endtask

    initial begin
        seed          = 65;
        random_delays = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
        model[0] = `RST_CONTROL;
        model[1] = `RST_STATUS;
        model[2] = `RST_CONFIG;
        model[3] = `RST_VERSION;
        rst_n   <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        repeat (2) @(posedge axi_if);
        rst_n <= 1'b1;
        @(posedge axi_if);

        begin_test("reset_values");
        for (int i = 0; i < `REG_COUNT; i++) read_and_check(test_name, `BASE_ADDR + addr_t'(4 * i));
        end_test();

        begin_test("full_writes");
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (!RO_BITS[i]) begin
                addr = `BASE_ADDR + addr_t'(4 * i);
                write_and_check(test_name, addr, data_t'($random(seed)), 4'hF);
                read_and_check(test_name, addr);
            end
        end
        end_test();

        begin_test("byte_merge");
        for (int i = 0; i < 8; i++) begin
            do begin
                idx = int'($unsigned($random(seed)) % 16);
            end while (RO_BITS[idx]);
            strb = (i == 0) ? 4'b0101 : strb_t'($random(seed));
            addr = `BASE_ADDR + addr_t'(4 * idx);
            write_and_check(test_name, addr, data_t'($random(seed)), strb);
            read_and_check(test_name, addr);
        end
        end_test();

        begin_test("ro_protect");
        write_and_check(test_name, `BASE_ADDR + 32'h4, 32'hFFFF_FFFF, 4'hF);
        read_and_check(test_name, `BASE_ADDR + 32'h4);
        write_and_check(test_name, `BASE_ADDR + 32'hC, 32'h5A5A_5A5A, 4'hF);
        read_and_check(test_name, `BASE_ADDR + 32'hC);
        end_test();

        begin_test("bad_addr");
        bad_list = '{`BASE_ADDR + 32'h1, `BASE_ADDR + 32'h16, `BASE_ADDR + 32'h27,
                     `BASE_ADDR + 32'h40, `BASE_ADDR + 32'h100, `BASE_ADDR - 32'h4};
        foreach (bad_list[k]) begin
            write_and_check(test_name, bad_list[k], data_t'($random(seed)), 4'hF);
            read_and_check(test_name, bad_list[k]);
            addr = {bad_list[k][31:2], 2'b00};  // neighbour word must be untouched
            if (addr >= `BASE_ADDR && addr < `BASE_ADDR + 32'h40) read_and_check(test_name, addr);
        end
        end_test();

        begin_test("random_mix");
        random_delays = 1'b1;
        for (int n = 0; n < 100; n++) begin
            op   = int'($unsigned($random(seed)) % 4);
            data = data_t'($random(seed));
            strb = strb_t'($random(seed));
            if (op < 2) begin
                write_and_check(test_name, random_addr(), data, strb);
            end else if (op == 2) begin
                read_and_check(test_name, random_addr());
            end else begin
                // write and read in flight together, on different words
                idx   = int'($unsigned($random(seed)) % 16);
                other = (idx + 1 + int'($unsigned($random(seed)) % 15)) % 16;
                fork
                    write_and_check(test_name, `BASE_ADDR + addr_t'(4 * idx), data, strb);
                    read_and_check(test_name, `BASE_ADDR + addr_t'(4 * other));
                join
            end
        end
        end_test();

        $display("summary: %0d checks, %0d errors, %0d assertion failures", check_count,
                 err_count, uut.u_asserts.assert_fails);
        if (err_count == 0 && uut.u_asserts.assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
